// File: Bender.yml
package:
  name: flash_boot

sources:
  # Loader RTL
  - include_dirs:
      - rtl
    files:
      - rtl/flash_boot_pkg.sv
      - rtl/boot_sequencer.sv
      - rtl/flash_read_timer.sv
      - rtl/word_assembler.sv
      - rtl/boot_imem.sv
      - rtl/flash_boot.sv
  # Testbench and flash model
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/flash_model.sv
      - verif/flash_boot_tb.sv

// File: flash_boot.f
+incdir+rtl
rtl/flash_boot_pkg.sv
rtl/boot_sequencer.sv
rtl/flash_read_timer.sv
rtl/word_assembler.sv
rtl/boot_imem.sv
rtl/flash_boot.sv
verif/flash_model.sv
verif/flash_boot_tb.sv

// File: rtl/boot_imem.sv
/*
 * Instruction memory for the boot image.
 * Loader writes through one port, the CPU fetches with one clock of latency.
 */

`default_nettype none

`include "flash_boot_settings.svh"

module boot_imem
(
	input  wire logic                        clk,
	input  wire logic                        we,
	input  wire logic [`IMEM_ADDR_BITS-1:0]  waddr,
	input  wire logic [31:0]                 wdata,
	input  wire logic [`IMEM_ADDR_BITS-1:0]  raddr,
	output logic [31:0]                      rdata
);

	// ==============================
	// Storage
	// ==============================

	logic [31:0] mem [`IMEM_DEPTH];

	// Loader side
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// CPU side, registered read
	// Same-address write shows the old word
	always_ff @(posedge clk)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// File: rtl/boot_sequencer.sv
/*
 * Boot loader FSM: checks the image header, copies the payload into
 * instruction memory and releases the CPU reset when the copy completes.
 */

`default_nettype none

`include "flash_boot_settings.svh"

module boot_sequencer
(
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        start,
	input  wire logic                        word_valid,
	input  wire flash_boot_pkg::flash_word_t word,
	output logic                             run,
	output logic                             clear,
	output logic                             imem_we,
	output logic [`IMEM_ADDR_BITS-1:0]       imem_waddr,
	output logic [31:0]                      imem_wdata,
	output logic                             cpu_reset,
	output logic                             done,
	output logic                             error
);

	import flash_boot_pkg::*;

	// One extra bit so a full memory count fits
	localparam int CNT_BITS = `IMEM_ADDR_BITS + 1;

	boot_state_t state_q;
	// Payload length from the header
	logic [CNT_BITS-1:0] count_q;
	// Words written so far
	logic [CNT_BITS-1:0] wr_cnt;
	logic hdr_ok;
	logic last_write;

	// ==============================
	// Header decode and write path
	// ==============================

	// Magic match and count within memory
	assign hdr_ok = (word.header.magic == `BOOT_MAGIC)
		&& (word.header.word_count <= 16'(`IMEM_DEPTH));

	assign last_write = (wr_cnt == count_q - CNT_BITS'(1));

	// Flash keeps running through header and payload
	assign run = (state_q == st_read_header) || (state_q == st_copy);
	// Restarts address and lane count for a new image
	assign clear = (state_q == st_idle) && start;

	// Write goes out in the same cycle the word arrives
	assign imem_we = (state_q == st_copy) && word_valid;
	assign imem_waddr = wr_cnt[`IMEM_ADDR_BITS-1:0];
	assign imem_wdata = word;

	// ==============================
	// State register
	// ==============================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= st_idle;
			count_q <= '0;
			wr_cnt <= '0;
			done <= 1'b0;
			error <= 1'b0;
			cpu_reset <= 1'b1;
		end
		else
		begin
			case (state_q)
				st_idle:
				begin
					// start counts only here
					if (start)
						state_q <= st_read_header;
				end
				st_read_header:
				begin
					if (word_valid)
					begin
						if (!hdr_ok)
						begin
							state_q <= st_error;
							error <= 1'b1;
						end
						else if (word.header.word_count == 16'd0)
						begin
							// Empty image needs no copy
							state_q <= st_done;
							done <= 1'b1;
							cpu_reset <= 1'b0;
						end
						else
						begin
							state_q <= st_copy;
							count_q <= word.header.word_count[CNT_BITS-1:0];
							wr_cnt <= '0;
						end
					end
				end
				st_copy:
				begin
					if (word_valid)
					begin
						wr_cnt <= wr_cnt + CNT_BITS'(1);
						// CPU leaves reset together with done
						if (last_write)
						begin
							state_q <= st_done;
							done <= 1'b1;
							cpu_reset <= 1'b0;
						end
					end
				end
				// done and error hold until reset
				default:
				begin
					state_q <= state_q;
				end
			endcase
		end
	end

	// Outcome flags are exclusive
	a_done_error_excl: assert property (@(posedge clk) disable iff (reset)
		!(done && error));

	// Writes only during copy and below the header count
	a_we_in_copy: assert property (@(posedge clk) disable iff (reset)
		imem_we |-> (state_q == st_copy) && ({1'b0, imem_waddr} < count_q));

endmodule

`default_nettype wire

// File: rtl/flash_boot.sv
/*
 * Flash boot loader top level.
 * Sits between the parallel flash pins and the CPU instruction fetch port.
 */

`default_nettype none

`include "flash_boot_settings.svh"

module flash_boot
(
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        start,
	input  wire logic [7:0]                  fl_dq,
	input  wire logic [`IMEM_ADDR_BITS-1:0]  imem_addr,
	output logic [21:0]                      fl_addr,
	output logic                             fl_ce_n,
	output logic                             fl_oe_n,
	output logic [31:0]                      imem_data,
	output logic                             cpu_reset,
	output logic                             done,
	output logic                             error
);

	import flash_boot_pkg::*;

	// Sequencer to timer
	logic run;
	logic clear;
	// Timer to assembler
	logic byte_strobe;
	// Assembler to sequencer
	logic word_valid;
	flash_word_t word;
	// Sequencer to memory
	logic imem_we;
	logic [`IMEM_ADDR_BITS-1:0] imem_waddr;
	logic [31:0] imem_wdata;

	// Flash enabled only while reading
	assign fl_ce_n = !run;
	assign fl_oe_n = !run;

	boot_sequencer seq_i
	(
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.word_valid (word_valid),
		.word       (word),
		.run        (run),
		.clear      (clear),
		.imem_we    (imem_we),
		.imem_waddr (imem_waddr),
		.imem_wdata (imem_wdata),
		.cpu_reset  (cpu_reset),
		.done       (done),
		.error      (error)
	);

	flash_read_timer timer_i
	(
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.clear       (clear),
		.byte_strobe (byte_strobe),
		.fl_addr     (fl_addr)
	);

	word_assembler asm_i
	(
		.clk         (clk),
		.reset       (reset),
		.byte_strobe (byte_strobe),
		.clear       (clear),
		.fl_dq       (fl_dq),
		.word_valid  (word_valid),
		.word        (word)
	);

	boot_imem imem_i
	(
		.clk   (clk),
		.we    (imem_we),
		.waddr (imem_waddr),
		.wdata (imem_wdata),
		.raddr (imem_addr),
		.rdata (imem_data)
	);

endmodule

`default_nettype wire

// File: rtl/flash_boot_pkg.sv
/*
 * Types shared by the flash boot loader blocks.
 * Ports name them with scoped names and bodies use a wildcard import.
 */

`default_nettype none

package flash_boot_pkg;

	// One flash word, big-endian as stored in the image
	typedef union packed
	{
		// Byte lanes, byte 0 is the most significant
		logic [0:3][7:0] bytes;
		// Header view of word 0
		struct packed
		{
			logic [15:0] magic;
			logic [15:0] word_count;
		} header;
	} flash_word_t;

	// Loader sequencer states
	typedef enum logic [2:0]
	{
		st_idle,
		st_read_header,
		st_copy,
		st_done,
		st_error
	} boot_state_t;

endpackage

`default_nettype wire

// File: rtl/flash_boot_settings.svh
/*
 * Build-time constants for the flash boot loader.
 * Include in every RTL file that needs flash timing or memory sizing.
 */

`ifndef FLASH_BOOT_SETTINGS_SVH
`define FLASH_BOOT_SETTINGS_SVH

// ==============================
// Flash timing
// ==============================

// Clocks each byte address is held before data is sampled
`define FLASH_WAIT_CYCLES 4

// ==============================
// Boot image format
// ==============================

// Required in the upper half of header word 0
`define BOOT_MAGIC 16'hB007

// Instruction memory size in 32-bit words
`define IMEM_DEPTH 256
// Must cover IMEM_DEPTH
`define IMEM_ADDR_BITS 8

`endif

// File: rtl/flash_read_timer.sv
/*
 * Paces byte reads from the parallel flash.
 * Holds each byte address for a fixed number of clocks and strobes the last one.
 */

`default_nettype none

`include "flash_boot_settings.svh"

module flash_read_timer
(
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        run,
	input  wire logic        clear,
	output logic             byte_strobe,
	output logic [21:0]      fl_addr
);

	// Wide enough for any wait count
	localparam int WAIT_BITS = $clog2(`FLASH_WAIT_CYCLES + 1);
	localparam logic [WAIT_BITS-1:0] WAIT_LAST = WAIT_BITS'(`FLASH_WAIT_CYCLES - 1);

	logic [WAIT_BITS-1:0] wait_cnt;
	logic [21:0] byte_addr;

	// Last clock of the hold where data has settled
	assign byte_strobe = (wait_cnt == WAIT_LAST);
	assign fl_addr = byte_addr;

	// ==============================
	// Wait and address counters
	// ==============================

	always_ff @(posedge clk)
	begin
		if (reset || clear)
		begin
			wait_cnt <= '0;
			byte_addr <= '0;
		end
		else if (run)
		begin
			if (wait_cnt == WAIT_LAST)
			begin
				// End of the period moves to the next byte
				wait_cnt <= '0;
				byte_addr <= byte_addr + 22'd1;
			end
			else
			begin
				wait_cnt <= wait_cnt + WAIT_BITS'(1);
			end
		end
		// Both counters frozen while stopped
	end

	// A sample with the flash disabled would be garbage
	a_strobe_needs_run: assert property (@(posedge clk) disable iff (reset)
		byte_strobe |-> run);

endmodule

`default_nettype wire

// File: rtl/word_assembler.sv
/*
 * Packs flash bytes into big-endian 32-bit words.
 * Pulses word_valid one clock after the fourth byte of each word.
 */

`default_nettype none

module word_assembler
(
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    byte_strobe,
	input  wire logic                    clear,
	input  wire logic [7:0]              fl_dq,
	output logic                         word_valid,
	output flash_boot_pkg::flash_word_t  word
);

	import flash_boot_pkg::*;

	// Byte position within the current word
	logic [1:0] lane;
	logic valid_q;
	flash_word_t word_q;

	assign word_valid = valid_q;
	assign word = word_q;

	// Control realigned by clear
	always_ff @(posedge clk)
	begin
		if (reset || clear)
		begin
			lane <= 2'd0;
			valid_q <= 1'b0;
		end
		else
		begin
			// Fourth byte completes the word
			valid_q <= byte_strobe && (lane == 2'd3);
			if (byte_strobe)
				lane <= lane + 2'd1;
		end
	end

	// Shift register that moves the first byte up to byte 0
	always_ff @(posedge clk)
	begin
		if (byte_strobe)
			word_q.bytes <= {word_q.bytes[1:3], fl_dq};
	end

endmodule

`default_nettype wire

// File: verif/flash_boot_tb.sv
/*
 * Testbench for the flash boot loader. Loads generated images through
 * the flash model, concurrent assertions below do the checking.
 */

`default_nettype none

`include "flash_boot_settings.svh"

module flash_boot_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// Enough for a full memory image plus margin
	localparam int LOAD_TIMEOUT = (`IMEM_DEPTH + 2) * 4 * `FLASH_WAIT_CYCLES + 100;

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic [`IMEM_ADDR_BITS-1:0] imem_addr;
	logic [7:0] fl_dq;
	logic [21:0] fl_addr;
	logic fl_ce_n;
	logic fl_oe_n;
	logic [31:0] imem_data;
	logic cpu_reset;
	logic done;
	logic error;

	// Bookkeeping
	string test_name = "none";
	int errors = 0;
	int errs_at_start = 0;
	int passed = 0;
	int failed = 0;
	logic [31:0] rand_state = 32'h5ca9;

	// Check enables, set by the test sequence
	logic started;
	logic expect_ok;
	logic expect_err;
	logic zero_test;
	logic rd_check;
	logic [31:0] rd_exp;
	// Delayed copies for the one-cycle read latency
	logic rd_chk_q;
	logic [31:0] rd_exp_q;
	// Samples spent on the current flash address
	int hold_cnt;
	logic [21:0] prev_addr;

	always #10 clk = ~clk;

	flash_boot dut_i
	(
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.fl_dq     (fl_dq),
		.imem_addr (imem_addr),
		.fl_addr   (fl_addr),
		.fl_ce_n   (fl_ce_n),
		.fl_oe_n   (fl_oe_n),
		.imem_data (imem_data),
		.cpu_reset (cpu_reset),
		.done      (done),
		.error     (error)
	);

	flash_model flash_i
	(
		.addr (fl_addr),
		.ce_n (fl_ce_n),
		.oe_n (fl_oe_n),
		.dq   (fl_dq)
	);

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("Error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errs_at_start = errors;
	endtask

	task automatic end_test();
		if (errors == errs_at_start)
		begin
			passed++;
			$display("Test %s: ok", test_name);
		end
		else
		begin
			failed++;
			$display("Test %s: %0d errors", test_name, errors - errs_at_start);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		reset = 1'b1;
		start = 1'b0;
		started = 1'b0;
		expect_ok = 1'b0;
		expect_err = 1'b0;
		zero_test = 1'b0;
		rd_check = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
	endtask

	// Header word, then payload_words random words
	task automatic load_image(input logic [15:0] magic, input logic [15:0] count,
		input int payload_words);
		flash_i.mem[0] = {magic, count};
		for (int i = 1; i <= payload_words; i++)
		begin
			rand_state = lcg_next(rand_state);
			flash_i.mem[i] = rand_state;
		end
	endtask

	task automatic pulse_start();
		@(posedge clk);
		#2;
		start = 1'b1;
		started = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
	endtask

	task automatic wait_finish();
		int n;
		n = 0;
		while (!(done || error) && n < LOAD_TIMEOUT)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		if (!(done || error))
		begin
			errors++;
			$display("Timeout in %s: neither done nor error rose", test_name);
		end
		// Some settled cycles for the level checks
		repeat (4) @(posedge clk);
	endtask

	task automatic wait_addr(input logic [21:0] target);
		int n;
		n = 0;
		while (fl_addr < target && n < LOAD_TIMEOUT)
		begin
			@(posedge clk);
			#2;
			n++;
		end
		if (fl_addr < target)
		begin
			errors++;
			$display("Timeout in %s: fl_addr never reached %0d", test_name, target);
		end
	endtask

	// Fetch words 0..words-1, expect image words 1..words
	task automatic read_back(input int words);
		for (int i = 0; i < words; i++)
		begin
			@(posedge clk);
			#2;
			imem_addr = i[`IMEM_ADDR_BITS-1:0];
			rd_exp = flash_i.mem[i + 1];
			rd_check = 1'b1;
		end
		@(posedge clk);
		#2;
		rd_check = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// ==============================
	// Checkers
	// ==============================

	always @(posedge clk)
	begin
		if (reset || fl_oe_n)
			hold_cnt <= 0;
		else if (hold_cnt != 0 && fl_addr != prev_addr)
			hold_cnt <= 1;
		else
			hold_cnt <= hold_cnt + 1;
		prev_addr <= fl_addr;
		rd_chk_q <= rd_check;
		rd_exp_q <= rd_exp;
	end

	// Quiet outputs until the first start, order done error cpu_reset ce_n oe_n
	a_idle: assert property (@(posedge clk) disable iff (reset)
		!started |-> !done && !error && cpu_reset && fl_ce_n && fl_oe_n)
		else report_mismatch("idle outputs", 5'b00111,
			$sampled({done, error, cpu_reset, fl_ce_n, fl_oe_n}));

	// CPU released exactly with done
	a_release: assert property (@(posedge clk) disable iff (reset)
		$rose(done) |-> $fell(cpu_reset))
		else report_mismatch("cpu_reset at done rise", 0, $sampled(cpu_reset));
	a_release_only: assert property (@(posedge clk) disable iff (reset)
		$fell(cpu_reset) |-> $rose(done))
		else report_mismatch("done at cpu_reset fall", 1, $sampled(done));

	a_good_load: assert property (@(posedge clk) disable iff (reset)
		expect_ok |-> !error)
		else report_mismatch("error", 0, $sampled(error));
	a_bad_load: assert property (@(posedge clk) disable iff (reset)
		expect_err |-> !done)
		else report_mismatch("done", 0, $sampled(done));

	// Error leaves the CPU in reset and the flash disabled, order done cpu_reset oe_n
	a_error_state: assert property (@(posedge clk) disable iff (reset)
		error |-> !done && cpu_reset && fl_oe_n)
		else report_mismatch("error outputs", 3'b011,
			$sampled({done, cpu_reset, fl_oe_n}));

	// Byte pacing
	a_hold: assert property (@(posedge clk) disable iff (reset)
		hold_cnt != 0 && !fl_oe_n && fl_addr != prev_addr |-> hold_cnt == `FLASH_WAIT_CYCLES)
		else report_mismatch("fl_addr hold cycles", `FLASH_WAIT_CYCLES, $sampled(hold_cnt));
	a_step: assert property (@(posedge clk) disable iff (reset)
		hold_cnt != 0 && !fl_oe_n && fl_addr != prev_addr |-> fl_addr == prev_addr + 22'd1)
		else report_mismatch("fl_addr step", $sampled(prev_addr) + 1, $sampled(fl_addr));

	// Address stops one past the header, that byte is never sampled
	a_zero: assert property (@(posedge clk) disable iff (reset)
		zero_test |-> fl_addr <= 22'd4)
		else report_mismatch("fl_addr bound", 4, $sampled(fl_addr));

	a_readback: assert property (@(posedge clk) disable iff (reset)
		rd_chk_q |-> imem_data == rd_exp_q)
		else report_mismatch("imem word", $sampled(rd_exp_q), $sampled(imem_data));

	// ==============================
	// Test sequence
	// ==============================

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		imem_addr = '0;
		started = 1'b0;
		expect_ok = 1'b0;
		expect_err = 1'b0;
		zero_test = 1'b0;
		rd_check = 1'b0;
		rd_exp = '0;

		begin_test("reset_idle");
		apply_reset();
		repeat (40) @(posedge clk);
		end_test();

		begin_test("valid_load");
		apply_reset();
		load_image(`BOOT_MAGIC, 16'd20, 20);
		expect_ok = 1'b1;
		pulse_start();
		// Second start partway through the payload
		wait_addr(22'd30);
		pulse_start();
		wait_finish();
		read_back(20);
		end_test();

		begin_test("bad_magic");
		apply_reset();
		load_image(`BOOT_MAGIC ^ 16'h0100, 16'd4, 4);
		expect_err = 1'b1;
		pulse_start();
		wait_finish();
		end_test();

		begin_test("count_too_big");
		apply_reset();
		load_image(`BOOT_MAGIC, 16'(`IMEM_DEPTH + 1), 4);
		expect_err = 1'b1;
		pulse_start();
		wait_finish();
		end_test();

		begin_test("zero_count");
		apply_reset();
		load_image(`BOOT_MAGIC, 16'd0, 0);
		expect_ok = 1'b1;
		zero_test = 1'b1;
		pulse_start();
		wait_finish();
		end_test();

		$display("Tests passed: %0d, failed: %0d", passed, failed);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/flash_model.sv
/*
 * Behavioral byte-wide parallel flash for the boot loader testbench.
 * The testbench fills mem with big-endian words before each load.
 */

`default_nettype none

module flash_model
#(
	parameter int DEPTH = 512
)
(
	input  wire logic [21:0] addr,
	input  wire logic        ce_n,
	input  wire logic        oe_n,
	output logic [7:0]       dq
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int IDX_BITS = $clog2(DEPTH);

	// Word storage, written by the testbench
	logic [31:0] mem [DEPTH];
	logic [31:0] word;

	// Unwritten words read back an index pattern
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = {i[15:0] ^ 16'h3c3c, ~i[15:0]};
	end

	// Asynchronous read, like the real part after its access time
	always_comb
	begin
		if (addr[21:2] < 20'(DEPTH))
			word = mem[addr[IDX_BITS+1:2]];
		else
			word = {addr[9:0], addr};
		// Bus floats high when disabled
		if (ce_n || oe_n)
			dq = 8'hff;
		else
			dq = word[8 * (3 - addr[1:0]) +: 8];
	end

endmodule

`default_nettype wire
